//--- sysbus_pkg.sv
package sysbus_pkg;

    // Bus and line geometry
    localparam int BUS_DATA_WIDTH    = 64;
    localparam int BUS_TAG_WIDTH     = 13;
    localparam int LINE_BEATS        = 8;
    localparam int LINE_WIDTH        = 512;
    localparam int LINE_OFFSET_WIDTH = 6;

    // Tag direction bit, bit 12 of the tag
    localparam logic SYSBUS_READ  = 1'b0;
    localparam logic SYSBUS_WRITE = 1'b1;

    // Device field, tag bits 11 to 8
    localparam logic [3:0] SYSBUS_MEMORY = 4'b0001;

    // Complete tags used by the line engines
    localparam logic [BUS_TAG_WIDTH-1:0] TAG_WRITE_MEMORY =
        {SYSBUS_WRITE, SYSBUS_MEMORY, 8'h00};
    localparam logic [BUS_TAG_WIDTH-1:0] TAG_READ_MEMORY =
        {SYSBUS_READ, SYSBUS_MEMORY, 8'h00};

    // Address view of a bus word
    typedef struct packed {
        logic [BUS_DATA_WIDTH-LINE_OFFSET_WIDTH-1:0] line_index;
        logic [LINE_OFFSET_WIDTH-1:0]                offset;
    } sysbus_addr_t;

    // One bus word, either raw data or a line address
    typedef union packed {
        logic [BUS_DATA_WIDTH-1:0] data;
        sysbus_addr_t              addr;
    } sysbus_word_t;

endpackage

//--- sysbus_if.sv
`timescale 1ns/1ps

interface sysbus_if;
    import sysbus_pkg::*;

    // Request channel, master to slave
    logic                      reqcyc;
    sysbus_word_t              req;
    logic [BUS_TAG_WIDTH-1:0]  reqtag;
    logic                      reqack;

    // Response channel, slave to master
    logic                      respcyc;
    logic [BUS_DATA_WIDTH-1:0] resp;
    logic [BUS_TAG_WIDTH-1:0]  resptag;
    logic                      respack;

    modport master
    (
        output reqcyc, req, reqtag, respack,
        input  reqack, respcyc, resp, resptag
    );

    modport slave
    (
        input  reqcyc, req, reqtag, respack,
        output reqack, respcyc, resp, resptag
    );

endinterface

//--- bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [1:0]                            request,
    output logic [1:0]                            grant,
    sysbus_if.slave                               writer_bus,
    sysbus_if.slave                               reader_bus,
    output logic                                  bus_reqcyc,
    input  logic                                  bus_reqack,
    output logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] bus_req,
    output logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  bus_reqtag,
    input  logic                                  bus_respcyc,
    output logic                                  bus_respack,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] bus_resp,
    input  logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  bus_resptag
);
    // Bit 0 is the writer, bit 1 the reader
    logic last_owner;
    logic pick;
    logic release_bus;

    // Round robin only matters when both ask at once
    always_comb
    begin
        if (&request)
        begin
            pick = ~last_owner;
        end
        else
        begin
            pick = request[1];
        end
    end

    assign release_bus = |(grant & ~request);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            grant      <= 2'b00;
            last_owner <= 1'b1;
        end
        else if (grant != 2'b00)
        begin
            if (release_bus)
            begin
                grant <= 2'b00;
            end
        end
        else if (|request)
        begin
            grant      <= pick ? 2'b10 : 2'b01;
            last_owner <= pick;
        end
    end

    // Owner's request channel goes out
    assign bus_reqcyc  = (grant[0] & writer_bus.reqcyc) | (grant[1] & reader_bus.reqcyc);
    assign bus_req     = grant[1] ? reader_bus.req.data : writer_bus.req.data;
    assign bus_reqtag  = grant[1] ? reader_bus.reqtag : writer_bus.reqtag;
    assign bus_respack = (grant[0] & writer_bus.respack) | (grant[1] & reader_bus.respack);

    // Handshakes come back to the owner only
    assign writer_bus.reqack  = grant[0] & bus_reqack;
    assign reader_bus.reqack  = grant[1] & bus_reqack;
    assign writer_bus.respcyc = grant[0] & bus_respcyc;
    assign reader_bus.respcyc = grant[1] & bus_respcyc;

    // Payload is shared, the cycle strobe qualifies it
    assign writer_bus.resp    = bus_resp;
    assign reader_bus.resp    = bus_resp;
    assign writer_bus.resptag = bus_resptag;
    assign reader_bus.resptag = bus_resptag;

endmodule

//--- line_writer.sv
`timescale 1ns/1ps

module line_writer
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  sysbus_pkg::sysbus_word_t          addr,
    input  logic [sysbus_pkg::LINE_WIDTH-1:0] line,
    output logic                              ready,
    output logic                              arb_request,
    input  logic                              arb_grant,
    sysbus_if.master                          bus
);
    import sysbus_pkg::*;

    typedef enum logic [2:0]
    {
        IDLE,
        GRANT_WAIT,
        ADDR_BEAT,
        DATA_BEATS,
        DONE
    } state_t;

    state_t                        state;
    state_t                        next_state;
    logic [$clog2(LINE_BEATS)-1:0] beat;
    logic                          accept_start;
    logic                          last_beat;
    sysbus_word_t                  addr_q;
    sysbus_word_t                  data_word;
    logic [LINE_WIDTH-1:0]         line_q;

    assign accept_start = start && (state == IDLE || state == DONE);
    assign last_beat    = bus.reqack && beat == $bits(beat)'(LINE_BEATS - 1);

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:       next_state = start ? GRANT_WAIT : IDLE;
            GRANT_WAIT: next_state = arb_grant ? ADDR_BEAT : GRANT_WAIT;
            ADDR_BEAT:  next_state = bus.reqack ? DATA_BEATS : ADDR_BEAT;
            DATA_BEATS: next_state = last_beat ? DONE : DATA_BEATS;
            DONE:       next_state = start ? GRANT_WAIT : DONE;
            default:    next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            beat  <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == ADDR_BEAT)
            begin
                beat <= '0;
            end
            else if (state == DATA_BEATS && bus.reqack)
            begin
                beat <= beat + 1'b1;
            end
        end
    end

    // Line is latched so the caller may move on
    always_ff @(posedge clk)
    begin
        if (accept_start)
        begin
            addr_q.addr.line_index <= addr.addr.line_index;
            addr_q.addr.offset     <= '0;
            line_q                 <= line;
        end
    end

    // Lowest word goes first
    assign data_word.data = line_q[beat*BUS_DATA_WIDTH +: BUS_DATA_WIDTH];

    assign bus.req     = (state == DATA_BEATS) ? data_word : addr_q;
    assign bus.reqcyc  = (state == ADDR_BEAT) || (state == DATA_BEATS);
    assign bus.reqtag  = TAG_WRITE_MEMORY;
    assign bus.respack = 1'b0;

    assign arb_request = (state == GRANT_WAIT) || (state == ADDR_BEAT) || (state == DATA_BEATS);
    assign ready       = (state == DONE);

endmodule

//--- line_reader.sv
`timescale 1ns/1ps

module line_reader
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  sysbus_pkg::sysbus_word_t          addr,
    output logic [sysbus_pkg::LINE_WIDTH-1:0] line,
    output logic                              ready,
    output logic                              arb_request,
    input  logic                              arb_grant,
    sysbus_if.master                          bus
);
    import sysbus_pkg::*;

    typedef enum logic [2:0]
    {
        IDLE,
        GRANT_WAIT,
        ADDR_BEAT,
        COLLECT,
        DONE
    } state_t;

    state_t                        state;
    state_t                        next_state;
    logic [$clog2(LINE_BEATS)-1:0] beat;
    logic                          accept_start;
    logic                          hit;
    logic                          last_beat;
    sysbus_word_t                  addr_q;
    logic [LINE_WIDTH-1:0]         line_q;

    assign accept_start = start && (state == IDLE || state == DONE);

    // Only our own read responses count
    assign hit       = (state == COLLECT) && bus.respcyc && bus.resptag == TAG_READ_MEMORY;
    assign last_beat = hit && beat == $bits(beat)'(LINE_BEATS - 1);

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:       next_state = start ? GRANT_WAIT : IDLE;
            GRANT_WAIT: next_state = arb_grant ? ADDR_BEAT : GRANT_WAIT;
            ADDR_BEAT:  next_state = bus.reqack ? COLLECT : ADDR_BEAT;
            COLLECT:    next_state = last_beat ? DONE : COLLECT;
            DONE:       next_state = start ? GRANT_WAIT : DONE;
            default:    next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            beat  <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == ADDR_BEAT)
            begin
                beat <= '0;
            end
            else if (hit)
            begin
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept_start)
        begin
            addr_q.addr.line_index <= addr.addr.line_index;
            addr_q.addr.offset     <= '0;
        end
    end

    // Words enter at the top, so the first one ends up lowest
    always_ff @(posedge clk)
    begin
        if (hit)
        begin
            line_q <= {bus.resp, line_q[LINE_WIDTH-1:BUS_DATA_WIDTH]};
        end
    end

    assign bus.req     = addr_q;
    assign bus.reqcyc  = (state == ADDR_BEAT);
    assign bus.reqtag  = TAG_READ_MEMORY;
    assign bus.respack = (state == COLLECT);

    assign arb_request = (state == GRANT_WAIT) || (state == ADDR_BEAT) || (state == COLLECT);
    assign ready       = (state == DONE);
    assign line        = line_q;

endmodule

//--- line_bus_top.sv
`timescale 1ns/1ps

module line_bus_top
(
    input  logic                                  clk,
    input  logic                                  reset,

    // Writer side
    input  logic                                  wr_start,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] wr_addr,
    input  logic [sysbus_pkg::LINE_WIDTH-1:0]     wr_line,
    output logic                                  wr_ready,

    // Reader side
    input  logic                                  rd_start,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] rd_addr,
    output logic [sysbus_pkg::LINE_WIDTH-1:0]     rd_line,
    output logic                                  rd_ready,

    // External system bus
    output logic                                  bus_reqcyc,
    input  logic                                  bus_reqack,
    output logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] bus_req,
    output logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  bus_reqtag,
    input  logic                                  bus_respcyc,
    output logic                                  bus_respack,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] bus_resp,
    input  logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  bus_resptag
);
    // Bit 0 is the writer, bit 1 the reader
    logic [1:0] arb_request;
    logic [1:0] arb_grant;

    sysbus_if writer_bus();
    sysbus_if reader_bus();

    line_writer i_line_writer
    (
        .clk         (clk),
        .reset       (reset),
        .start       (wr_start),
        .addr        (wr_addr),
        .line        (wr_line),
        .ready       (wr_ready),
        .arb_request (arb_request[0]),
        .arb_grant   (arb_grant[0]),
        .bus         (writer_bus.master)
    );

    line_reader i_line_reader
    (
        .clk         (clk),
        .reset       (reset),
        .start       (rd_start),
        .addr        (rd_addr),
        .line        (rd_line),
        .ready       (rd_ready),
        .arb_request (arb_request[1]),
        .arb_grant   (arb_grant[1]),
        .bus         (reader_bus.master)
    );

    bus_arbiter i_bus_arbiter
    (
        .clk         (clk),
        .reset       (reset),
        .request     (arb_request),
        .grant       (arb_grant),
        .writer_bus  (writer_bus.slave),
        .reader_bus  (reader_bus.slave),
        .bus_reqcyc  (bus_reqcyc),
        .bus_reqack  (bus_reqack),
        .bus_req     (bus_req),
        .bus_reqtag  (bus_reqtag),
        .bus_respcyc (bus_respcyc),
        .bus_respack (bus_respack),
        .bus_resp    (bus_resp),
        .bus_resptag (bus_resptag)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk,
    output logic reset
);
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Three rising edges see reset, release on a falling edge
    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- bus_memory_model.sv
`timescale 1ns/1ps

module bus_memory_model
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  bus_reqcyc,
    output logic                                  bus_reqack,
    input  logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] bus_req,
    input  logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  bus_reqtag,
    output logic                                  bus_respcyc,
    input  logic                                  bus_respack,
    output logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] bus_resp,
    output logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  bus_resptag
);
    import sysbus_pkg::*;

    logic [LINE_WIDTH-1:0] lines [logic [BUS_DATA_WIDTH-LINE_OFFSET_WIDTH-1:0]];
    sysbus_word_t          req_word;
    logic [LINE_WIDTH-1:0] write_buf;
    logic [LINE_WIDTH-1:0] read_buf;
    logic [BUS_DATA_WIDTH-LINE_OFFSET_WIDTH-1:0] write_index;
    int unsigned           write_left;
    int unsigned           read_left;
    int unsigned           ack_wait;
    int unsigned           resp_wait;

    assign req_word.data = bus_req;

    // Untouched lines hold a pattern built from the full line index
    function automatic logic [LINE_WIDTH-1:0] fill_line(
        logic [BUS_DATA_WIDTH-LINE_OFFSET_WIDTH-1:0] index);
        logic [LINE_WIDTH-1:0] value;
        for (int w = 0; w < LINE_BEATS; w++)
        begin
            value[w*BUS_DATA_WIDTH +: BUS_DATA_WIDTH] = {3'b101, index, 3'(w)};
        end
        return value;
    endfunction

    always @(posedge clk)
    begin
        if (reset)
        begin
            bus_reqack  <= 1'b0;
            bus_respcyc <= 1'b0;
            bus_resp    <= '0;
            bus_resptag <= '0;
            write_left  = 0;
            read_left   = 0;
            ack_wait    = 0;
            resp_wait   = 0;
        end
        else
        begin
            if (bus_reqcyc && bus_reqack)
            begin
                bus_reqack <= 1'b0;
                ack_wait   = $urandom_range(0, 3);
                if (write_left > 0)
                begin
                    // Data beats arrive lowest word first
                    write_buf  = {req_word.data, write_buf[LINE_WIDTH-1:BUS_DATA_WIDTH]};
                    write_left = write_left - 1;
                    if (write_left == 0)
                    begin
                        lines[write_index] = write_buf;
                    end
                end
                else if (bus_reqtag == TAG_WRITE_MEMORY)
                begin
                    write_index = req_word.addr.line_index;
                    write_left  = LINE_BEATS;
                end
                else if (bus_reqtag == TAG_READ_MEMORY)
                begin
                    read_buf = lines.exists(req_word.addr.line_index) ?
                        lines[req_word.addr.line_index] : fill_line(req_word.addr.line_index);
                    read_left = LINE_BEATS;
                    resp_wait = $urandom_range(0, 3);
                end
            end
            else if (bus_reqcyc)
            begin
                if (ack_wait == 0)
                begin
                    bus_reqack <= 1'b1;
                end
                else
                begin
                    ack_wait = ack_wait - 1;
                end
            end

            if (bus_respcyc && bus_respack)
            begin
                bus_respcyc <= 1'b0;
                read_left   = read_left - 1;
                resp_wait   = $urandom_range(0, 3);
            end
            else if (!bus_respcyc && read_left > 0)
            begin
                if (resp_wait == 0)
                begin
                    bus_respcyc <= 1'b1;
                    bus_resp    <= read_buf[BUS_DATA_WIDTH-1:0];
                    bus_resptag <= TAG_READ_MEMORY;
                    read_buf    = read_buf >> BUS_DATA_WIDTH;
                end
                else
                begin
                    resp_wait = resp_wait - 1;
                end
            end
        end
    end

endmodule

//--- line_bus_assertions.sv
`timescale 1ns/1ps

module line_bus_assertions
(
    input logic                                  clk,
    input logic                                  reset,
    input logic [1:0]                            request,
    input logic [1:0]                            grant,
    input logic                                  writer_reqcyc,
    input logic                                  reader_reqcyc,
    input logic                                  bus_reqcyc,
    input logic                                  bus_reqack,
    input logic [sysbus_pkg::BUS_DATA_WIDTH-1:0] bus_req,
    input logic [sysbus_pkg::BUS_TAG_WIDTH-1:0]  bus_reqtag
);
    import sysbus_pkg::*;

    // A new grant goes only to an engine that was asking for the bus
    grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant) && (grant & ~$past(grant) & ~$past(request)) == 2'b00)
        else $error("Grant is not one-hot or went to an engine that did not request");

    // A beat that is not acknowledged stays on the bus unchanged
    req_stable: assert property (@(posedge clk) disable iff (reset)
        bus_reqcyc && !bus_reqack |=> bus_reqcyc && $stable(bus_req) && $stable(bus_reqtag))
        else $error("Request beat changed while waiting for reqack");

    // Engines put a beat out only while they own the bus
    reqcyc_granted: assert property (@(posedge clk) disable iff (reset)
        (!writer_reqcyc || grant[0]) && (!reader_reqcyc || grant[1]))
        else $error("An engine raised reqcyc with no grant held");

    // Every transfer opens with its address beat
    line_aligned: assert property (@(posedge clk) disable iff (reset)
        $rose(bus_reqcyc) |-> bus_req[LINE_OFFSET_WIDTH-1:0] == '0)
        else $error("Address beat carries nonzero offset bits");

endmodule

bind bus_arbiter line_bus_assertions i_line_bus_assertions
(
    .clk           (clk),
    .reset         (reset),
    .request       (request),
    .grant         (grant),
    .writer_reqcyc (writer_bus.reqcyc),
    .reader_reqcyc (reader_bus.reqcyc),
    .bus_reqcyc    (bus_reqcyc),
    .bus_reqack    (bus_reqack),
    .bus_req       (bus_req),
    .bus_reqtag    (bus_reqtag)
);

//--- line_bus_tb.sv
`timescale 1ns/1ps

module line_bus_tb;
    import sysbus_pkg::*;

    logic                      clk;
    logic                      reset;
    logic                      wr_start;
    logic                      rd_start;
    logic                      wr_ready;
    logic                      rd_ready;
    logic [BUS_DATA_WIDTH-1:0] wr_addr;
    logic [BUS_DATA_WIDTH-1:0] rd_addr;
    logic [LINE_WIDTH-1:0]     wr_line;
    logic [LINE_WIDTH-1:0]     rd_line;
    logic                      bus_reqcyc;
    logic                      bus_reqack;
    logic [BUS_DATA_WIDTH-1:0] bus_req;
    logic [BUS_TAG_WIDTH-1:0]  bus_reqtag;
    logic                      bus_respcyc;
    logic                      bus_respack;
    logic [BUS_DATA_WIDTH-1:0] bus_resp;
    logic [BUS_TAG_WIDTH-1:0]  bus_resptag;

    logic [LINE_WIDTH-1:0]     shadow [logic [BUS_DATA_WIDTH-LINE_OFFSET_WIDTH-1:0]];
    logic [BUS_DATA_WIDTH-1:0] read_addr_q;
    logic                      rd_ready_q = 1'b0;
    int                        reads_issued = 0;
    int                        reads_checked = 0;

    tb_clock_gen     i_tb_clock_gen (.*);
    line_bus_top     i_line_bus_top (.*);
    bus_memory_model i_bus_memory_model (.*);

    task automatic fail_run();
        $display("RESULT: FAIL");
        $fatal(1, "Testbench stopped at the first failure");
    endtask

    task automatic check_value(string what, logic [LINE_WIDTH-1:0] actual,
                               logic [LINE_WIDTH-1:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            fail_run();
        end
    endtask

    // Written lines come from the shadow, the rest from the fill pattern
    function automatic logic [LINE_WIDTH-1:0] expected_line(logic [BUS_DATA_WIDTH-1:0] addr);
        logic [BUS_DATA_WIDTH-LINE_OFFSET_WIDTH-1:0] index;
        logic [LINE_WIDTH-1:0]                        value;
        index = addr[BUS_DATA_WIDTH-1:LINE_OFFSET_WIDTH];
        for (int w = 0; w < LINE_BEATS; w++)
        begin
            value[w*BUS_DATA_WIDTH +: BUS_DATA_WIDTH] = {3'b101, index, 3'(w)};
        end
        if (shadow.exists(index))
        begin
            value = shadow[index];
        end
        return value;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] random_line();
        logic [LINE_WIDTH-1:0] value;
        for (int i = 0; i < LINE_WIDTH / 32; i++)
        begin
            value[i*32 +: 32] = $urandom();
        end
        return value;
    endfunction

    // Sixteen lines, any byte offset
    function automatic logic [BUS_DATA_WIDTH-1:0] random_addr();
        return 64'h0000_0040_0000_0000
            + {54'd0, 4'($urandom_range(0, 15)), 6'($urandom_range(0, 63))};
    endfunction

    task automatic write_line(logic [BUS_DATA_WIDTH-1:0] addr, logic [LINE_WIDTH-1:0] data);
        wr_addr  = addr;
        wr_line  = data;
        wr_start = 1'b1;
        shadow[addr[BUS_DATA_WIDTH-1:LINE_OFFSET_WIDTH]] = data;
    endtask

    task automatic read_line(logic [BUS_DATA_WIDTH-1:0] addr);
        rd_addr      = addr;
        rd_start     = 1'b1;
        read_addr_q  = addr;
        reads_issued = reads_issued + 1;
    endtask

    // Ends the start pulses and waits for every started engine
    task automatic wait_done();
        logic wr_busy;
        logic rd_busy;
        @(negedge clk);
        wr_busy  = wr_start;
        rd_busy  = rd_start;
        wr_start = 1'b0;
        rd_start = 1'b0;
        while ((wr_busy && !wr_ready) || (rd_busy && !rd_ready))
        begin
            @(negedge clk);
        end
    endtask

    always @(negedge clk)
    begin
        if (rd_ready && !rd_ready_q)
        begin
            check_value("rd_line", rd_line, expected_line(read_addr_q));
            reads_checked = reads_checked + 1;
        end
        rd_ready_q = rd_ready;
    end

    initial
    begin
        logic [BUS_DATA_WIDTH-1:0] addr;
        void'($urandom(32'hfb0a));
        wr_start = 1'b0;
        rd_start = 1'b0;
        wr_addr  = '0;
        rd_addr  = '0;
        wr_line  = '0;
        @(negedge reset);
        check_value("wr_ready after reset", LINE_WIDTH'(wr_ready), '0);
        check_value("rd_ready after reset", LINE_WIDTH'(rd_ready), '0);
        check_value("bus_reqcyc after reset", LINE_WIDTH'(bus_reqcyc), '0);

        @(negedge clk);
        write_line(64'h0000_0040_0000_1000, random_line());
        wait_done();
        @(negedge clk);
        read_line(64'h0000_0040_0000_1000);
        wait_done();

        // Offset bits of the write address are dropped
        @(negedge clk);
        write_line(64'h0000_0040_0000_2025, random_line());
        wait_done();
        @(negedge clk);
        read_line(64'h0000_0040_0000_2000);
        wait_done();

        @(negedge clk);
        write_line(64'h0000_0040_0000_3000, random_line());
        read_line(64'h0000_0040_0000_1000);
        wait_done();

        // Writer owned the bus last, so the reader wins this pair
        @(negedge clk);
        write_line(64'h0000_0040_0000_4000, random_line());
        wait_done();
        @(negedge clk);
        write_line(64'h0000_0040_0000_5000, random_line());
        read_line(64'h0000_0040_0000_3000);
        wait_done();

        for (int i = 0; i < 40; i++)
        begin
            addr = random_addr();
            @(negedge clk);
            if ($urandom_range(0, 1) == 1)
            begin
                write_line(addr, random_line());
            end
            else
            begin
                read_line(addr);
            end
            wait_done();
        end

        @(negedge clk);
        check_value("reads checked", LINE_WIDTH'(reads_checked), LINE_WIDTH'(reads_issued));
        $display("RESULT: PASS");
        $finish;
    end

    // 49 transfers, each a grant and nine beats of up to five cycles, with margin
    initial
    begin
        int unsigned limit_ns;
        limit_ns = 49 * 2 * (4 + 9 * 5) * 8 + 100;
        #(limit_ns);
        $display("Timeout: the transfers did not finish within %0d ns", limit_ns);
        fail_run();
    end

endmodule

//--- src.f
sysbus_pkg.sv
sysbus_if.sv
bus_arbiter.sv
line_writer.sv
line_reader.sv
line_bus_top.sv
tb_clock_gen.sv
bus_memory_model.sv
line_bus_assertions.sv
line_bus_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= line_bus_tb
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
BUILD_DIR ?= obj_dir

SOURCES := $(shell cat src.f)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(SOURCES) src.f
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f src.f

run: $(BINARY)
	@output="$$($(BINARY))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
